// ==== rtl/ecdsa_pkg.sv ====
package ecdsa_pkg;

  // Stream and scalar geometry
  localparam int WORD_BITS        = 64;
  localparam int SCALAR_BITS      = 256;
  localparam int WORDS_PER_SCALAR = SCALAR_BITS / WORD_BITS;

  // secp256k1 group order
  localparam logic [SCALAR_BITS-1:0] CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  localparam logic [15:0] CMD_VERIFY_PREP = 16'h0101;
  localparam logic [15:0] RPL_VERIFY_PREP = 16'h0102;

  // Header, index, then s, r and z
  localparam int CMD_WORDS = 2 + 3 * WORDS_PER_SCALAR;
  // Header, index, then u1 and u2
  localparam int RPL_WORDS = 2 + 2 * WORDS_PER_SCALAR;

  typedef logic [SCALAR_BITS-1:0] scalar_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] dat;
    logic                 sop;
    logic                 eop;
  } stream_beat_t;

  typedef struct packed {
    logic [15:0] cmd;
    logic [7:0]  flags;
    logic [39:0] pad;
  } hdr_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic       out_of_range_r;
    logic       out_of_range_s;
  } ver_flags_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] index;
    scalar_t              s;
    scalar_t              r;
    scalar_t              z;
  } job_t;

endpackage

// ==== rtl/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  ecdsa_pkg::stream_beat_t i_cmd,
  input  logic                    i_cmd_val,
  output logic                    o_cmd_rdy,
  input  logic                    i_full,
  output logic                    o_push,
  output ecdsa_pkg::job_t         o_job
);

  typedef enum logic [1:0] {
    ST_HDR,
    ST_COLLECT,
    ST_SKIP
  } state_t;

  localparam int W = ecdsa_pkg::WORD_BITS;

  state_t           state;
  logic [3:0]       word_cnt;
  logic             accept;
  logic             last_word;
  ecdsa_pkg::hdr_t  hdr;

  // Stall the source while no slot is free for the next record
  assign o_cmd_rdy = ~i_full;
  assign accept    = i_cmd_val & o_cmd_rdy;
  assign hdr       = i_cmd.dat;
  // word_cnt counts the words after the header
  assign last_word = word_cnt == 4'(ecdsa_pkg::CMD_WORDS - 2);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_HDR;
      word_cnt <= '0;
      o_push   <= 1'b0;
    end else begin
      o_push <= 1'b0;
      if (accept) begin
        case (state)
          ST_HDR: begin
            word_cnt <= '0;
            if (!i_cmd.eop) begin
              state <= (hdr.cmd == ecdsa_pkg::CMD_VERIFY_PREP) ? ST_COLLECT : ST_SKIP;
            end
          end
          ST_COLLECT: begin
            word_cnt <= word_cnt + 4'd1;
            if (last_word) begin
              o_push <= 1'b1;
              state  <= i_cmd.eop ? ST_HDR : ST_SKIP;
            end else if (i_cmd.eop) begin
              // Short frame, drop it
              state <= ST_HDR;
            end
          end
          default: begin
            if (i_cmd.eop) begin
              state <= ST_HDR;
            end
          end
        endcase
      end
    end
  end

  // Scalars arrive least significant word first, so shift in from the top
  always_ff @(posedge i_clk) begin
    if (accept && state == ST_COLLECT) begin
      case (word_cnt) inside
        4'd0:          o_job.index <= i_cmd.dat;
        [4'd1:4'd4]:   o_job.s     <= {i_cmd.dat, o_job.s[ecdsa_pkg::SCALAR_BITS-1:W]};
        [4'd5:4'd8]:   o_job.r     <= {i_cmd.dat, o_job.r[ecdsa_pkg::SCALAR_BITS-1:W]};
        default:       o_job.z     <= {i_cmd.dat, o_job.z[ecdsa_pkg::SCALAR_BITS-1:W]};
      endcase
    end
  end

endmodule

// ==== rtl/job_fifo.sv ====
`timescale 1ns/1ps

module job_fifo #(
  parameter int JOB_DEPTH = 2
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_push,
  input  ecdsa_pkg::job_t i_job,
  output logic            o_full,
  output logic            o_ready,
  input  logic            i_pop,
  output ecdsa_pkg::job_t o_job
);

  localparam int PTR_W = $clog2(JOB_DEPTH);
  localparam int CNT_W = $clog2(JOB_DEPTH + 1);

  ecdsa_pkg::job_t  mem [JOB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;

  // Pointers wrap at JOB_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(JOB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    count_nxt = count;
    if (i_push && !i_pop) begin
      count_nxt = count + 1'b1;
    end else if (!i_push && i_pop) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_full  <= 1'b0;
      o_ready <= 1'b0;
    end else begin
      if (i_push) wr_ptr <= ptr_inc(wr_ptr);
      if (i_pop)  rd_ptr <= ptr_inc(rd_ptr);
      count   <= count_nxt;
      o_full  <= count_nxt == CNT_W'(JOB_DEPTH);
      o_ready <= count_nxt != '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_job;
    end
  end

  assign o_job = mem[rd_ptr];

endmodule

// ==== rtl/mod_inv.sv ====
`timescale 1ns/1ps

module mod_inv (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  ecdsa_pkg::scalar_t i_a,
  output logic               o_done,
  output ecdsa_pkg::scalar_t o_inv
);

  localparam ecdsa_pkg::scalar_t N = ecdsa_pkg::CURVE_N;

  // Invariants: x1 * a == u and x2 * a == v, both mod n
  ecdsa_pkg::scalar_t u;
  ecdsa_pkg::scalar_t v;
  ecdsa_pkg::scalar_t x1;
  ecdsa_pkg::scalar_t x2;
  ecdsa_pkg::scalar_t u_nxt;
  ecdsa_pkg::scalar_t v_nxt;
  ecdsa_pkg::scalar_t x1_nxt;
  ecdsa_pkg::scalar_t x2_nxt;
  logic               busy;
  logic               finish;

  // x / 2 mod n, odd values get n added first
  function automatic ecdsa_pkg::scalar_t half_mod(input ecdsa_pkg::scalar_t x);
    logic [ecdsa_pkg::SCALAR_BITS:0] t;
    t = x[0] ? ({1'b0, x} + {1'b0, N}) : {1'b0, x};
    return t[ecdsa_pkg::SCALAR_BITS:1];
  endfunction

  function automatic ecdsa_pkg::scalar_t sub_mod(input ecdsa_pkg::scalar_t a,
                                                 input ecdsa_pkg::scalar_t b);
    ecdsa_pkg::scalar_t d;
    d = a - b;
    if (a < b) d = d + N;
    return d;
  endfunction

  assign finish = (u == ecdsa_pkg::scalar_t'(1)) || (v == ecdsa_pkg::scalar_t'(1));

  // One step per cycle; an odd-odd step subtracts and halves together
  always_comb begin
    u_nxt  = u;
    v_nxt  = v;
    x1_nxt = x1;
    x2_nxt = x2;
    if (!u[0] || !v[0]) begin
      if (!u[0]) begin
        u_nxt  = u >> 1;
        x1_nxt = half_mod(x1);
      end
      if (!v[0]) begin
        v_nxt  = v >> 1;
        x2_nxt = half_mod(x2);
      end
    end else if (u >= v) begin
      u_nxt  = (u - v) >> 1;
      x1_nxt = half_mod(sub_mod(x1, x2));
    end else begin
      v_nxt  = (v - u) >> 1;
      x2_nxt = half_mod(sub_mod(x2, x1));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
      end else if (busy && finish) begin
        busy   <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      u  <= i_a;
      v  <= N;
      x1 <= ecdsa_pkg::scalar_t'(1);
      x2 <= '0;
    end else if (busy) begin
      if (finish) begin
        o_inv <= (u == ecdsa_pkg::scalar_t'(1)) ? x1 : x2;
      end else begin
        u  <= u_nxt;
        v  <= v_nxt;
        x1 <= x1_nxt;
        x2 <= x2_nxt;
      end
    end
  end

endmodule

// ==== rtl/mod_mult.sv ====
`timescale 1ns/1ps

module mod_mult (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  ecdsa_pkg::scalar_t i_a,
  input  ecdsa_pkg::scalar_t i_b,
  output logic               o_done,
  output ecdsa_pkg::scalar_t o_prod
);

  localparam int SB  = ecdsa_pkg::SCALAR_BITS;
  localparam int CW  = $clog2(SB);
  localparam logic [SB:0] N_EXT = {1'b0, ecdsa_pkg::CURVE_N};

  // a must be below n, b may be any 256-bit value
  ecdsa_pkg::scalar_t a_q;
  ecdsa_pkg::scalar_t b_q;
  logic [CW-1:0]      bit_cnt;
  logic               busy;
  logic [SB:0]        dbl;
  logic [SB:0]        sum;

  // acc = 2*acc (+ a) mod n, reduced after each of the two additions
  always_comb begin
    dbl = {o_prod, 1'b0};
    if (dbl >= N_EXT) dbl = dbl - N_EXT;
    sum = dbl + (b_q[SB-1] ? {1'b0, a_q} : '0);
    if (sum >= N_EXT) sum = sum - N_EXT;
  end

  // 256 steps follow the start cycle, done lands on cycle 257
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == CW'(SB - 1)) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      a_q    <= i_a;
      b_q    <= i_b;
      o_prod <= '0;
    end else if (busy) begin
      o_prod <= sum[SB-1:0];
      b_q    <= b_q << 1;
    end
  end

endmodule

// ==== rtl/scalar_engine.sv ====
`timescale 1ns/1ps

module scalar_engine (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_ready,
  input  ecdsa_pkg::job_t         i_job,
  output logic                    o_pop,
  output ecdsa_pkg::stream_beat_t o_rpl,
  output logic                    o_rpl_val,
  input  logic                    i_rpl_rdy
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_INVERT,
    ST_PROD_U1,
    ST_PROD_U2,
    ST_SEND
  } state_t;

  localparam int W        = ecdsa_pkg::WORD_BITS;
  localparam int RPL_BITS = ecdsa_pkg::RPL_WORDS * W;
  localparam int CNT_W    = $clog2(ecdsa_pkg::RPL_WORDS);

  state_t                   state;
  ecdsa_pkg::job_t          job_q;
  ecdsa_pkg::scalar_t       u1_q;
  logic [RPL_BITS-1:0]      rpl_sr;
  logic [CNT_W-1:0]         rpl_cnt;
  ecdsa_pkg::ver_flags_t    chk_flags;
  ecdsa_pkg::hdr_t          rpl_hdr;
  logic                     inv_start;
  logic                     inv_done;
  ecdsa_pkg::scalar_t       inv_res;
  logic                     mult_start;
  logic                     mult_done;
  ecdsa_pkg::scalar_t       mult_res;

  assign o_pop = (state == ST_IDLE) && i_ready;

  // Both values must lie in 1 .. n-1
  always_comb begin
    chk_flags                = '0;
    chk_flags.out_of_range_s = (job_q.s == '0) || (job_q.s >= ecdsa_pkg::CURVE_N);
    chk_flags.out_of_range_r = (job_q.r == '0) || (job_q.r >= ecdsa_pkg::CURVE_N);
  end

  // Flags stay zero for jobs that reach the products
  always_comb begin
    rpl_hdr       = '0;
    rpl_hdr.cmd   = ecdsa_pkg::RPL_VERIFY_PREP;
    rpl_hdr.flags = chk_flags;
  end

  assign o_rpl.dat = rpl_sr[W-1:0];
  assign o_rpl.sop = rpl_cnt == '0;
  assign o_rpl.eop = rpl_cnt == CNT_W'(ecdsa_pkg::RPL_WORDS - 1);
  assign o_rpl_val = state == ST_SEND;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= ST_IDLE;
      rpl_cnt    <= '0;
      inv_start  <= 1'b0;
      mult_start <= 1'b0;
    end else begin
      inv_start  <= 1'b0;
      mult_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_ready) state <= ST_CHECK;
        end
        ST_CHECK: begin
          if (|chk_flags) begin
            state <= ST_SEND;
          end else begin
            inv_start <= 1'b1;
            state     <= ST_INVERT;
          end
        end
        ST_INVERT: begin
          if (inv_done) begin
            mult_start <= 1'b1;
            state      <= ST_PROD_U1;
          end
        end
        ST_PROD_U1: begin
          if (mult_done) begin
            mult_start <= 1'b1;
            state      <= ST_PROD_U2;
          end
        end
        ST_PROD_U2: begin
          if (mult_done) state <= ST_SEND;
        end
        default: begin
          if (i_rpl_rdy) begin
            rpl_cnt <= rpl_cnt + 1'b1;
            if (o_rpl.eop) begin
              rpl_cnt <= '0;
              state   <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Reply layout from the bottom: header, index, u1, u2
  always_ff @(posedge i_clk) begin
    if (o_pop) job_q <= i_job;
    if (state == ST_PROD_U1 && mult_done) u1_q <= mult_res;
    if (state == ST_CHECK) begin
      rpl_sr <= {{(2 * ecdsa_pkg::SCALAR_BITS){1'b0}}, job_q.index, rpl_hdr};
    end else if (state == ST_PROD_U2 && mult_done) begin
      rpl_sr <= {mult_res, u1_q, job_q.index, rpl_hdr};
    end else if (state == ST_SEND && i_rpl_rdy) begin
      rpl_sr <= rpl_sr >> W;
    end
  end

  mod_inv mod_inv_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (inv_start),
    .i_a     (job_q.s),
    .o_done  (inv_done),
    .o_inv   (inv_res)
  );

  // w = s^-1 stays on the inverse output through both products
  mod_mult mod_mult_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (mult_start),
    .i_a     (inv_res),
    .i_b     ((state == ST_PROD_U2) ? job_q.r : job_q.z),
    .o_done  (mult_done),
    .o_prod  (mult_res)
  );

endmodule

// ==== rtl/ecdsa_prep_top.sv ====
`timescale 1ns/1ps

module ecdsa_prep_top #(
  parameter int JOB_DEPTH = 2
) (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  ecdsa_pkg::stream_beat_t i_cmd,
  input  logic                    i_cmd_val,
  output logic                    o_cmd_rdy,
  output ecdsa_pkg::stream_beat_t o_rpl,
  output logic                    o_rpl_val,
  input  logic                    i_rpl_rdy
);

  logic            fifo_full;
  logic            fifo_push;
  logic            fifo_ready;
  logic            fifo_pop;
  ecdsa_pkg::job_t push_job;
  ecdsa_pkg::job_t head_job;

  cmd_parser cmd_parser_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .i_cmd_val (i_cmd_val),
    .o_cmd_rdy (o_cmd_rdy),
    .i_full    (fifo_full),
    .o_push    (fifo_push),
    .o_job     (push_job)
  );

  // Lets the next command arrive while the engine is still busy
  job_fifo #(
    .JOB_DEPTH (JOB_DEPTH)
  ) job_fifo_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (fifo_push),
    .i_job   (push_job),
    .o_full  (fifo_full),
    .o_ready (fifo_ready),
    .i_pop   (fifo_pop),
    .o_job   (head_job)
  );

  scalar_engine scalar_engine_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ready   (fifo_ready),
    .i_job     (head_job),
    .o_pop     (fifo_pop),
    .o_rpl     (o_rpl),
    .o_rpl_val (o_rpl_val),
    .i_rpl_rdy (i_rpl_rdy)
  );

endmodule

// ==== test/ecdsa_prep_sva.sv ====
`timescale 1ns/1ps

module ecdsa_prep_sva (
  input logic                    i_clk,
  input logic                    i_rst,
  input ecdsa_pkg::stream_beat_t i_rpl,
  input logic                    i_rpl_val,
  input logic                    i_rpl_rdy
);

  int         hold_fails = 0;
  int         rst_fails  = 0;
  int         len_fails  = 0;
  int         fail_cnt;
  logic [3:0] beat_cnt;
  logic       beat_acc;

  assign fail_cnt = hold_fails + rst_fails + len_fails;
  assign beat_acc = i_rpl_val & i_rpl_rdy;

  // Words of the current reply accepted so far
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      beat_cnt <= '0;
    end else if (beat_acc) begin
      beat_cnt <= i_rpl.sop ? 4'd1 : beat_cnt + 4'd1;
    end
  end

  hold_while_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rpl_val && !i_rpl_rdy |=> i_rpl_val && $stable(i_rpl))
  else begin
    hold_fails = hold_fails + 1;
    $error("reply word or valid changed while the sink stalled");
  end

  idle_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_rpl_val)
  else begin
    rst_fails = rst_fails + 1;
    $error("reply valid high in the cycle after reset");
  end

  // Ten accepted words from sop through eop
  frame_length: assert property (@(posedge i_clk) disable iff (i_rst)
    beat_acc && i_rpl.eop |-> !i_rpl.sop && beat_cnt == 4'(ecdsa_pkg::RPL_WORDS - 1))
  else begin
    len_fails = len_fails + 1;
    $error("reply frame does not hold ten words");
  end

endmodule

bind ecdsa_prep_top ecdsa_prep_sva ecdsa_prep_sva_inst (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_rpl     (o_rpl),
  .i_rpl_val (o_rpl_val),
  .i_rpl_rdy (i_rpl_rdy)
);

// ==== test/ecdsa_prep_tb.sv ====
`timescale 1ns/1ps

module ecdsa_prep_tb;

  localparam ecdsa_pkg::scalar_t N = ecdsa_pkg::CURVE_N;
  localparam int WAIT_LIMIT = 20000;

  // Laid out like the reply stream, header in the low word
  typedef struct packed {
    ecdsa_pkg::scalar_t u2;
    ecdsa_pkg::scalar_t u1;
    logic [63:0]        index;
    ecdsa_pkg::hdr_t    hdr;
  } reply_t;

  logic                    clk;
  logic                    rst;
  ecdsa_pkg::stream_beat_t cmd;
  logic                    cmd_val;
  logic                    cmd_rdy;
  ecdsa_pkg::stream_beat_t rpl;
  logic                    rpl_val;
  logic                    rpl_rdy;
  logic                    rdy_random;
  integer                  seed;
  int                      errors;
  int                      checks;
  int                      replies;
  int                      tests;
  reply_t                  exp_q[$];
  string                   name_q[$];

  ecdsa_prep_top #(
    .JOB_DEPTH (2)
  ) ecdsa_prep_top_inst (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_cmd     (cmd),
    .i_cmd_val (cmd_val),
    .o_cmd_rdy (cmd_rdy),
    .o_rpl     (rpl),
    .o_rpl_val (rpl_val),
    .i_rpl_rdy (rpl_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic ecdsa_pkg::scalar_t mul_mod(input ecdsa_pkg::scalar_t a,
                                                 input ecdsa_pkg::scalar_t b);
    logic [511:0] p;
    p = {256'd0, a} * {256'd0, b};
    p = p % {256'd0, N};
    return p[255:0];
  endfunction

  // n is prime, so s^(n-2) is the inverse of s
  function automatic ecdsa_pkg::scalar_t pow_mod(input ecdsa_pkg::scalar_t b,
                                                 input ecdsa_pkg::scalar_t e);
    ecdsa_pkg::scalar_t acc;
    acc = 256'd1;
    for (int i = 255; i >= 0; i--) begin
      acc = mul_mod(acc, acc);
      if (e[i]) acc = mul_mod(acc, b);
    end
    return acc;
  endfunction

  function automatic reply_t ref_reply(input logic [63:0] index, input ecdsa_pkg::scalar_t s,
                                       input ecdsa_pkg::scalar_t r,
                                       input ecdsa_pkg::scalar_t z);
    ecdsa_pkg::ver_flags_t flags;
    ecdsa_pkg::scalar_t    w;
    reply_t                e;
    flags                = '0;
    flags.out_of_range_s = (s == '0) || (s >= N);
    flags.out_of_range_r = (r == '0) || (r >= N);
    e           = '0;
    e.hdr.cmd   = ecdsa_pkg::RPL_VERIFY_PREP;
    e.hdr.flags = flags;
    e.index     = index;
    if (flags == '0) begin
      w    = pow_mod(s, N - 256'd2);
      e.u1 = mul_mod(z, w);
      e.u2 = mul_mod(r, w);
    end
    return e;
  endfunction

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic ecdsa_pkg::scalar_t rand_scalar();
    ecdsa_pkg::scalar_t v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      v = {v[191:0], rand_word()};
    end
    v = v % N;
    return (v == '0) ? 256'd1 : v;
  endfunction

  task automatic check_hdr(input string name, input ecdsa_pkg::hdr_t exp,
                           input ecdsa_pkg::hdr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s header: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input string field, input logic [63:0] exp,
                            input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_scalar(input string name, input string field,
                              input ecdsa_pkg::scalar_t exp, input ecdsa_pkg::scalar_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
    end
  endtask

  // Holds the word until the DUT accepts it on a rising edge
  task automatic send_word(input logic [63:0] dat, input logic sop, input logic eop);
    int waited;
    waited  = 0;
    cmd.dat = dat;
    cmd.sop = sop;
    cmd.eop = eop;
    cmd_val = 1'b1;
    while (!cmd_rdy && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!cmd_rdy) begin
      errors++;
      $display("command input stayed not ready for %0d cycles", WAIT_LIMIT);
    end
    @(posedge clk);
    #1;
    cmd_val = 1'b0;
  endtask

  task automatic send_request(input string name, input logic [63:0] index,
                              input ecdsa_pkg::scalar_t s, input ecdsa_pkg::scalar_t r,
                              input ecdsa_pkg::scalar_t z);
    ecdsa_pkg::hdr_t hdr;
    exp_q.push_back(ref_reply(index, s, r, z));
    name_q.push_back(name);
    hdr     = '0;
    hdr.cmd = ecdsa_pkg::CMD_VERIFY_PREP;
    send_word(hdr, 1'b1, 1'b0);
    send_word(index, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) send_word(s[64*i +: 64], 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) send_word(r[64*i +: 64], 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) send_word(z[64*i +: 64], 1'b0, i == 3);
  endtask

  task automatic send_unknown();
    ecdsa_pkg::hdr_t hdr;
    hdr     = '0;
    hdr.cmd = 16'h0BAD;
    send_word(hdr, 1'b1, 1'b0);
    for (int i = 0; i < 4; i++) send_word(rand_word(), 1'b0, i == 3);
  endtask

  task automatic wait_replies();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d replies still missing after %0d cycles", exp_q.size(), WAIT_LIMIT);
      exp_q.delete();
      name_q.delete();
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors found");
  endtask

  initial begin
    integer rnd;
    rpl_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (rdy_random) begin
        rnd     = $random(seed);
        rpl_rdy = rnd[0];
      end else begin
        rpl_rdy = 1'b1;
      end
    end
  end

  // Reply monitor, samples on the falling edge where the stream is steady
  initial begin : collect
    reply_t act;
    reply_t exp;
    string  name;
    int     cnt;
    cnt = 0;
    act = '0;
    forever begin
      @(negedge clk);
      if (!rst && rpl_val && rpl_rdy) begin
        if ((cnt == 0) != rpl.sop) begin
          errors++;
          $display("reply word %0d carries a wrong sop mark", cnt);
        end
        if (cnt < ecdsa_pkg::RPL_WORDS) act[64*cnt +: 64] = rpl.dat;
        cnt++;
        if (rpl.eop) begin
          replies++;
          if (exp_q.size() == 0) begin
            errors++;
            $display("reply arrived with no request outstanding");
          end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            if (cnt != ecdsa_pkg::RPL_WORDS) begin
              errors++;
              $display("reply for %s had %0d words", name, cnt);
            end else begin
              check_hdr(name, exp.hdr, act.hdr);
              check_word(name, "index", exp.index, act.index);
              check_scalar(name, "u1", exp.u1, act.u1);
              check_scalar(name, "u2", exp.u2, act.u2);
            end
          end
          cnt = 0;
        end
      end
    end
  end

  initial begin : stimulus
    ecdsa_pkg::scalar_t s_arr   [8];
    ecdsa_pkg::scalar_t r_arr   [8];
    ecdsa_pkg::scalar_t z_arr   [8];
    logic [63:0]        idx_arr [8];
    int                 err_before;
    int                 rpl_before;
    int                 sva_fails;
    seed       = 98;
    errors     = 0;
    checks     = 0;
    replies    = 0;
    tests      = 0;
    rdy_random = 1'b0;
    rst        = 1'b1;
    cmd        = '0;
    cmd_val    = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    err_before = errors;
    if (rpl_val !== 1'b0 || cmd_rdy !== 1'b1) begin
      errors++;
      $display("after reset o_rpl_val is %b and o_cmd_rdy is %b", rpl_val, cmd_rdy);
    end
    send_request("single", rand_word(), rand_scalar(), rand_scalar(), rand_scalar());
    wait_replies();
    finish_test("single", err_before);

    err_before = errors;
    send_request("s_zero", rand_word(), '0, rand_scalar(), rand_scalar());
    send_request("s_order", rand_word(), N, rand_scalar(), rand_scalar());
    wait_replies();
    finish_test("range_s", err_before);

    err_before = errors;
    send_request("r_high", rand_word(), rand_scalar(), N + 256'd5, rand_scalar());
    send_request("both_bad", rand_word(), '1, '0, rand_scalar());
    wait_replies();
    finish_test("range_r", err_before);

    // The unknown frame must not produce a reply of its own
    err_before = errors;
    rpl_before = replies;
    send_unknown();
    send_request("after_unknown", rand_word(), rand_scalar(), rand_scalar(), rand_scalar());
    wait_replies();
    if (replies - rpl_before != 1) begin
      errors++;
      $display("expected one reply after the unknown command, got %0d",
               replies - rpl_before);
    end
    finish_test("unknown", err_before);

    err_before = errors;
    for (int i = 0; i < 8; i++) begin
      idx_arr[i] = rand_word();
      s_arr[i]   = rand_scalar();
      r_arr[i]   = rand_scalar();
      z_arr[i]   = rand_scalar();
    end
    rdy_random = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_request($sformatf("stream_%0d", i), idx_arr[i], s_arr[i], r_arr[i], z_arr[i]);
    end
    wait_replies();
    rdy_random = 1'b0;
    finish_test("stream", err_before);

    sva_fails = ecdsa_prep_top_inst.ecdsa_prep_sva_inst.fail_cnt;
    $display("tests %0d, replies %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, replies, checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== ecdsa_prep.f ====
rtl/ecdsa_pkg.sv
rtl/cmd_parser.sv
rtl/job_fifo.sv
rtl/mod_inv.sv
rtl/mod_mult.sv
rtl/scalar_engine.sv
rtl/ecdsa_prep_top.sv
test/ecdsa_prep_sva.sv
test/ecdsa_prep_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ecdsa_prep_tb \
  -f ecdsa_prep.f \
  -o ecdsa_prep_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/ecdsa_prep_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation run returned status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
